// File: beeb_glue_pkg.sv
// shared constants and the core address union; RAM window is smaller than the 18-bit RAM view
package beeb_glue_pkg;

	// ====================
	// memory port
	// ====================

	localparam int MEM_ADDR_W   = 19;
	localparam int ROM_BANK_W   = 4;
	localparam int ROM_OFFSET_W = 14;
	localparam int ROM_ADDR_W   = ROM_BANK_W + ROM_OFFSET_W;
	localparam int DATA_W       = 8;

	// sixteen 16 KB banks
	localparam int ROM_DEPTH = 262144;
	// co-pro, sideways, main, shadow and slot 8 RAM
	localparam int RAM_DEPTH = 212992;

	// top bit picks RAM over paged ROM
	// rom view splits the rest into slot and offset,
	// ram view keeps it as one flat offset
	typedef union packed {
		struct packed {
			logic                    is_ram;
			logic [ROM_BANK_W-1:0]   slot;
			logic [ROM_OFFSET_W-1:0] offset;
		} rom;
		struct packed {
			logic                  is_ram;
			logic [MEM_ADDR_W-2:0] offset;
		} ram;
	} mem_addr_t;

	// ====================
	// mouse and joystick
	// ====================

	// per-packet delta limit
	localparam int MOUSE_STEP_MAX = 10;
	// absolute position limits
	localparam int AXIS_MIN = -128;
	localparam int AXIS_MAX = 127;
	// signed position, one bit of headroom over the byte
	localparam int MOUSE_POS_W = 9;
	// byte plus repeated upper nibble
	localparam int JOY_AXIS_W = 12;

	// ====================
	// sd activity
	// ====================

	// LED hold in clk_sys cycles
	localparam int SD_ACT_HOLD = 2000000;
	localparam int SD_CNT_W    = $clog2(SD_ACT_HOLD + 1);

endpackage

// File: rom_slot_map.sv
// pure decode; model must already be settled, unlisted slots give bank 0 and read as zero
`timescale 1ns/1ps

module rom_slot_map (
	input  logic                                 model_master,
	input  logic                                 mmfs_v2,
	input  logic [beeb_glue_pkg::ROM_BANK_W-1:0] slot,
	output logic [beeb_glue_pkg::ROM_BANK_W-1:0] bank,
	output logic                                 visible
);
	import beeb_glue_pkg::*;

	// key is {model, logical slot}
	always_comb begin
		bank    = '0;
		visible = 1'b0;
		case ({model_master, slot})
			// ====================
			// model B
			// ====================
			5'b0_0011: begin
				// DFS image parked here, not paged in
				bank = 4'd4;
			end
			5'b0_0100: begin
				// OS high ROM
				bank    = 4'd0;
				visible = 1'b1;
			end
			5'b0_1000: begin
				// split ROM/RAM slot for MMFS, RAM side wins
				bank = mmfs_v2 ? 4'd14 : 4'd1;
			end
			5'b0_1110: begin
				bank    = 4'd4;
				visible = 1'b1;
			end
			5'b0_1111: begin
				// BASIC
				bank    = 4'd3;
				visible = 1'b1;
			end
			// ====================
			// Master
			// ====================
			5'b1_0011: begin
				// filing system image, version picks the bank
				bank    = mmfs_v2 ? 4'd15 : 4'd5;
				visible = 1'b1;
			end
			5'b1_0100: begin
				// MOS high ROM
				bank    = 4'd6;
				visible = 1'b1;
			end
			5'b1_1001, 5'b1_1010, 5'b1_1011, 5'b1_1100,
			5'b1_1101, 5'b1_1110, 5'b1_1111: begin
				// slots 9..15 packed down onto banks 7..13
				bank    = slot - 4'd2;
				visible = 1'b1;
			end
			default: begin
				bank    = '0;
				visible = 1'b0;
			end
		endcase
	end

endmodule

// File: beeb_memory.sv
// read latency is one cycle; RAM offsets at or above RAM_DEPTH are not written and read undefined
`timescale 1ns/1ps

module beeb_memory (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  beeb_glue_pkg::mem_addr_t             mem_addr,
	input  logic                                 mem_we_n,
	input  logic [beeb_glue_pkg::DATA_W-1:0]     mem_din,
	input  logic                                 load_wr,
	input  logic [beeb_glue_pkg::ROM_ADDR_W-1:0] load_addr,
	input  logic [beeb_glue_pkg::DATA_W-1:0]     load_data,
	input  logic                                 model_master,
	input  logic                                 mmfs_v2,
	output logic [beeb_glue_pkg::DATA_W-1:0]     mem_dout
);
	import beeb_glue_pkg::*;

	logic                  model_q;
	logic                  we_n_q;
	logic                  ram_wr;
	logic [ROM_BANK_W-1:0] bank;
	logic                  visible;
	logic [ROM_ADDR_W-1:0] rom_rd_addr;
	logic [DATA_W-1:0]     rom_mem [ROM_DEPTH];
	logic [DATA_W-1:0]     ram_mem [RAM_DEPTH];
	logic [DATA_W-1:0]     rom_q;
	logic [DATA_W-1:0]     ram_q;
	logic                  ram_sel_q;
	logic                  visible_q;

	// model tracks the switch only while held in reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			model_q <= model_master;
		end
	end

	// strobe history for the falling edge
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= mem_we_n;
		end
	end

	rom_slot_map u_slot_map (
		.model_master (model_q),
		.mmfs_v2      (mmfs_v2),
		.slot         (mem_addr.rom.slot),
		.bank         (bank),
		.visible      (visible)
	);

	assign rom_rd_addr = {bank, mem_addr.rom.offset};

	// ====================
	// ROM and RAM arrays
	// ====================

	// load port always wins the write side
	always_ff @(posedge clk_sys) begin
		if (load_wr) begin
			rom_mem[load_addr] <= load_data;
		end
		rom_q <= rom_mem[rom_rd_addr];
	end

	// one write per low pulse of mem_we_n
	assign ram_wr = mem_addr.ram.is_ram && we_n_q && !mem_we_n
		&& (mem_addr.ram.offset < RAM_DEPTH);

	always_ff @(posedge clk_sys) begin
		if (ram_wr) begin
			ram_mem[mem_addr.ram.offset] <= mem_din;
		end
		ram_q <= ram_mem[mem_addr.ram.offset];
	end

	// select flags ride along with the read data
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ram_sel_q <= 1'b0;
			visible_q <= 1'b0;
		end else begin
			ram_sel_q <= mem_addr.rom.is_ram;
			visible_q <= visible;
		end
	end

	// hidden slots read as zero
	assign mem_dout = ram_sel_q ? ram_q : (visible_q ? rom_q : '0);

	// core must always drive the write strobe
	a_we_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$isunknown(mem_we_n))
		else $error("mem_we_n unknown");

endmodule

// File: mouse_joystick.sv
// strobe bit 24 must toggle once per packet; any joystick 1 button drops back to analog input
`timescale 1ns/1ps

module mouse_joystick (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  logic [24:0]                          ps2_mouse,
	input  logic [15:0]                          joy1_buttons,
	input  logic [7:0]                           joy1_x,
	input  logic [7:0]                           joy1_y,
	input  logic [7:0]                           joy2_x,
	input  logic [7:0]                           joy2_y,
	input  logic                                 joy2_fire,
	input  logic                                 mouse_disable,
	input  logic                                 swap_joy,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick1_x,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick1_y,
	output logic                                 joystick1_fire_n,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick2_x,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick2_y,
	output logic                                 joystick2_fire_n
);
	import beeb_glue_pkg::*;

	logic                          stb_q;
	logic                          emu_on;
	logic signed [MOUSE_POS_W-1:0] pos_x;
	logic signed [MOUSE_POS_W-1:0] pos_y;
	logic signed [MOUSE_POS_W-1:0] dx;
	logic signed [MOUSE_POS_W-1:0] dy;
	logic signed [MOUSE_POS_W-1:0] dx_c;
	logic signed [MOUSE_POS_W-1:0] dy_c;
	logic [7:0]                    src_a_x;
	logic [7:0]                    src_a_y;
	logic                          fire_a;
	logic [JOY_AXIS_W-1:0]         axis_a_x;
	logic [JOY_AXIS_W-1:0]         axis_a_y;
	logic [JOY_AXIS_W-1:0]         axis_b_x;
	logic [JOY_AXIS_W-1:0]         axis_b_y;

	// saturate a signed value into [lim_lo, lim_hi]
	function automatic logic signed [MOUSE_POS_W-1:0] clamp(
		input logic signed [MOUSE_POS_W-1:0] v,
		input int                            lim_lo,
		input int                            lim_hi
	);
		return (v < lim_lo) ? MOUSE_POS_W'(lim_lo)
			: (v > lim_hi) ? MOUSE_POS_W'(lim_hi) : v;
	endfunction

	// centre-offset byte, inverted, then top nibble repeated
	function automatic logic [JOY_AXIS_W-1:0] conv_axis(input logic [7:0] v);
		logic [7:0] b;
		b = 8'hff - {~v[7], v[6:0]};
		return {b, b[7:4]};
	endfunction

	// ====================
	// mouse accumulation
	// ====================

	// 7-bit deltas, sign kept in the status byte
	assign dx = {ps2_mouse[4], ps2_mouse[4], ps2_mouse[15:9]};
	assign dy = {ps2_mouse[5], ps2_mouse[5], ps2_mouse[23:17]};

	assign dx_c = clamp(dx, -MOUSE_STEP_MAX, MOUSE_STEP_MAX);
	assign dy_c = clamp(dy, -MOUSE_STEP_MAX, MOUSE_STEP_MAX);

	// packet strobe history
	always_ff @(posedge clk_sys) begin
		stb_q <= ps2_mouse[24];
	end

	// clear beats a pending packet
	always_ff @(posedge clk_sys) begin
		if (!rst_n || mouse_disable || (|joy1_buttons)) begin
			emu_on <= 1'b0;
			pos_x  <= '0;
			pos_y  <= '0;
		end else if (stb_q != ps2_mouse[24]) begin
			emu_on <= 1'b1;
			pos_x  <= clamp(pos_x + dx_c, AXIS_MIN, AXIS_MAX);
			// screen y runs opposite to mouse y
			pos_y  <= clamp(pos_y - dy_c, AXIS_MIN, AXIS_MAX);
		end
	end

	// ====================
	// sources and swap
	// ====================

	assign src_a_x = emu_on ? pos_x[7:0] : joy1_x;
	assign src_a_y = emu_on ? pos_y[7:0] : joy1_y;
	assign fire_a  = emu_on ? (|ps2_mouse[1:0]) : joy1_buttons[4];

	assign axis_a_x = conv_axis(src_a_x);
	assign axis_a_y = conv_axis(src_a_y);
	assign axis_b_x = conv_axis(joy2_x);
	assign axis_b_y = conv_axis(joy2_y);

	assign joystick1_x = swap_joy ? axis_b_x : axis_a_x;
	assign joystick1_y = swap_joy ? axis_b_y : axis_a_y;
	// joystick 2 axes stay on source A
	assign joystick2_x = axis_a_x;
	assign joystick2_y = axis_a_y;

	// fire lines active low
	assign joystick1_fire_n = ~(swap_joy ? joy2_fire : fire_a);
	assign joystick2_fire_n = ~(swap_joy ? fire_a : joy2_fire);

	a_pos_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(pos_x >= AXIS_MIN) && (pos_x <= AXIS_MAX)
		&& (pos_y >= AXIS_MIN) && (pos_y <= AXIS_MAX))
		else $error("mouse position out of range");

	a_disable_clears: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mouse_disable |=> !emu_on)
		else $error("emulation flag set after mouse_disable");

endmodule

// File: sd_activity.sv
// SPI lines must already be in clk_sys; LED holds for SD_ACT_HOLD cycles after the last change
`timescale 1ns/1ps

module sd_activity (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic spi_mosi,
	input  logic spi_miso,
	output logic sd_led
);
	import beeb_glue_pkg::*;

	logic                mosi_q;
	logic                miso_q;
	logic                line_change;
	logic [SD_CNT_W-1:0] hold_cnt;

	// line history
	always_ff @(posedge clk_sys) begin
		mosi_q <= spi_mosi;
		miso_q <= spi_miso;
	end

	assign line_change = (mosi_q ^ spi_mosi) | (miso_q ^ spi_miso);

	// counter parked at the limit means idle
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hold_cnt <= SD_CNT_W'(SD_ACT_HOLD);
			sd_led   <= 1'b0;
		end else begin
			sd_led <= (hold_cnt < SD_ACT_HOLD);
			if (line_change) begin
				hold_cnt <= '0;
			end else if (hold_cnt < SD_ACT_HOLD) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	a_cnt_sat: assert property (@(posedge clk_sys) disable iff (!rst_n)
		hold_cnt <= SD_ACT_HOLD)
		else $error("sd hold counter past limit");

endmodule

// File: beeb_glue.sv
// single clk_sys domain; model_master only takes effect while rst_n is held low
`timescale 1ns/1ps

module beeb_glue (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  beeb_glue_pkg::mem_addr_t             mem_addr,
	input  logic                                 mem_we_n,
	input  logic [beeb_glue_pkg::DATA_W-1:0]     mem_din,
	input  logic                                 load_wr,
	input  logic [beeb_glue_pkg::ROM_ADDR_W-1:0] load_addr,
	input  logic [beeb_glue_pkg::DATA_W-1:0]     load_data,
	input  logic                                 model_master,
	input  logic                                 mmfs_v2,
	input  logic [24:0]                          ps2_mouse,
	input  logic [15:0]                          joy1_buttons,
	input  logic [7:0]                           joy1_x,
	input  logic [7:0]                           joy1_y,
	input  logic [7:0]                           joy2_x,
	input  logic [7:0]                           joy2_y,
	input  logic                                 joy2_fire,
	input  logic                                 mouse_disable,
	input  logic                                 swap_joy,
	input  logic                                 spi_mosi,
	input  logic                                 spi_miso,
	output logic [beeb_glue_pkg::DATA_W-1:0]     mem_dout,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick1_x,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick1_y,
	output logic                                 joystick1_fire_n,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick2_x,
	output logic [beeb_glue_pkg::JOY_AXIS_W-1:0] joystick2_y,
	output logic                                 joystick2_fire_n,
	output logic                                 sd_led
);

	// paged ROM, RAM and the external memory port
	beeb_memory u_memory (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.mem_addr     (mem_addr),
		.mem_we_n     (mem_we_n),
		.mem_din      (mem_din),
		.load_wr      (load_wr),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.model_master (model_master),
		.mmfs_v2      (mmfs_v2),
		.mem_dout     (mem_dout)
	);

	// mouse as analog joystick 1
	mouse_joystick u_mouse_joy (
		.clk_sys          (clk_sys),
		.rst_n            (rst_n),
		.ps2_mouse        (ps2_mouse),
		.joy1_buttons     (joy1_buttons),
		.joy1_x           (joy1_x),
		.joy1_y           (joy1_y),
		.joy2_x           (joy2_x),
		.joy2_y           (joy2_y),
		.joy2_fire        (joy2_fire),
		.mouse_disable    (mouse_disable),
		.swap_joy         (swap_joy),
		.joystick1_x      (joystick1_x),
		.joystick1_y      (joystick1_y),
		.joystick1_fire_n (joystick1_fire_n),
		.joystick2_x      (joystick2_x),
		.joystick2_y      (joystick2_y),
		.joystick2_fire_n (joystick2_fire_n)
	);

	// disk LED
	sd_activity u_sd_act (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.sd_led   (sd_led)
	);

endmodule

// File: tb_beeb_glue.sv
// ROM is loaded only at both ends of each bank; model changes go through a 16-cycle reset
`timescale 1ns/1ps

module tb_beeb_glue;
	import beeb_glue_pkg::*;

	// roughly 1100 cycles of tests with a wide margin on top
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	mem_addr_t   mem_addr;
	logic        mem_we_n;
	logic [7:0]  mem_din;
	logic        load_wr;
	logic [17:0] load_addr;
	logic [7:0]  load_data;
	logic        model_master;
	logic        mmfs_v2;
	logic [24:0] ps2_mouse;
	logic [15:0] joy1_buttons;
	logic [7:0]  joy1_x;
	logic [7:0]  joy1_y;
	logic [7:0]  joy2_x;
	logic [7:0]  joy2_y;
	logic        joy2_fire;
	logic        mouse_disable;
	logic        swap_joy;
	logic        spi_mosi;
	logic        spi_miso;
	logic [7:0]  mem_dout;
	logic [11:0] joystick1_x;
	logic [11:0] joystick1_y;
	logic        joystick1_fire_n;
	logic [11:0] joystick2_x;
	logic [11:0] joystick2_y;
	logic        joystick2_fire_n;
	logic        sd_led;

	// expected values and their enables for the compare process
	logic [7:0]  exp_dout;
	logic [11:0] exp_j1x;
	logic [11:0] exp_j1y;
	logic [11:0] exp_j2x;
	logic [11:0] exp_j2y;
	logic        exp_j1f;
	logic        exp_j2f;
	logic        exp_led;
	logic        dout_chk = 1'b0;
	logic        j1_chk = 1'b0;
	logic        j2_chk = 1'b0;
	logic        led_chk = 1'b0;
	int          n_checks = 0;
	int          n_errors = 0;
	int          cycle_cnt = 0;
	logic [31:0] lcg_state = 32'd10;

	// RAM shadow for the write test
	logic [17:0] ram_offs [$];
	logic [7:0]  ram_ref [logic [17:0]];

	beeb_glue dut (
		.clk_sys          (clk_sys),
		.rst_n            (rst_n),
		.mem_addr         (mem_addr),
		.mem_we_n         (mem_we_n),
		.mem_din          (mem_din),
		.load_wr          (load_wr),
		.load_addr        (load_addr),
		.load_data        (load_data),
		.model_master     (model_master),
		.mmfs_v2          (mmfs_v2),
		.ps2_mouse        (ps2_mouse),
		.joy1_buttons     (joy1_buttons),
		.joy1_x           (joy1_x),
		.joy1_y           (joy1_y),
		.joy2_x           (joy2_x),
		.joy2_y           (joy2_y),
		.joy2_fire        (joy2_fire),
		.mouse_disable    (mouse_disable),
		.swap_joy         (swap_joy),
		.spi_mosi         (spi_mosi),
		.spi_miso         (spi_miso),
		.mem_dout         (mem_dout),
		.joystick1_x      (joystick1_x),
		.joystick1_y      (joystick1_y),
		.joystick1_fire_n (joystick1_fire_n),
		.joystick2_x      (joystick2_x),
		.joystick2_y      (joystick2_y),
		.joystick2_fire_n (joystick2_fire_n),
		.sd_led           (sd_led)
	);

	// 8 ns clock
	always #4 clk_sys = ~clk_sys;

	// ====================
	// reference models
	// ====================

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		// halves swapped since low LCG bits are weak
		return {lcg_state[15:0], lcg_state[31:16]};
	endfunction

	// nonzero fill byte built from every address bit
	function automatic logic [7:0] rom_fill(input logic [17:0] a);
		return a[7:0] ^ a[15:8] ^ {2'b00, a[17:14], 2'b00} ^ 8'h5a;
	endfunction

	// returns {visible, bank}
	function automatic logic [4:0] ref_rom_map(input logic master, input logic v2,
		input logic [3:0] slot);
		if (!master) begin
			case (slot)
				4'd3: return {1'b0, 4'd4};
				4'd4: return {1'b1, 4'd0};
				4'd8: return {1'b0, v2 ? 4'd14 : 4'd1};
				4'd14: return {1'b1, 4'd4};
				4'd15: return {1'b1, 4'd3};
				default: return 5'd0;
			endcase
		end
		if (slot == 4'd3) begin
			return {1'b1, v2 ? 4'd15 : 4'd5};
		end
		if (slot == 4'd4) begin
			return {1'b1, 4'd6};
		end
		// slots 9..15 onto banks 7..13
		if (slot >= 4'd9) begin
			return {1'b1, slot - 4'd2};
		end
		return 5'd0;
	endfunction

	// inverted offset byte followed by its upper nibble
	function automatic logic [11:0] ref_axis(input logic [7:0] v);
		logic [7:0] b;
		b = 8'd255 - (v ^ 8'h80);
		return {b, b[7:4]};
	endfunction

	function automatic int field_delta(input logic sign, input logic [6:0] field);
		return sign ? int'(field) - 128 : int'(field);
	endfunction

	function automatic int saturate(input int v, input int lo, input int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	// ====================
	// compare and timeout
	// ====================

	task automatic compare_val(input string name, input logic [31:0] got,
		input logic [31:0] want);
		n_checks = n_checks + 1;
		if (got !== want) begin
			n_errors = n_errors + 1;
			$display("error at %0d ns: %s got %0h expected %0h", $time, name, got, want);
		end
	endtask

	// sampled mid-cycle where the outputs are stable
	always @(negedge clk_sys) begin
		if (dout_chk) begin
			compare_val("mem_dout", 32'(mem_dout), 32'(exp_dout));
		end
		if (j1_chk) begin
			compare_val("joystick1_x", 32'(joystick1_x), 32'(exp_j1x));
			compare_val("joystick1_y", 32'(joystick1_y), 32'(exp_j1y));
			compare_val("joystick1_fire_n", 32'(joystick1_fire_n), 32'(exp_j1f));
		end
		if (j2_chk) begin
			compare_val("joystick2_x", 32'(joystick2_x), 32'(exp_j2x));
			compare_val("joystick2_y", 32'(joystick2_y), 32'(exp_j2y));
			compare_val("joystick2_fire_n", 32'(joystick2_fire_n), 32'(exp_j2f));
		end
		if (led_chk) begin
			compare_val("sd_led", 32'(sd_led), 32'(exp_led));
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ====================
	// stimulus helpers
	// ====================

	// inputs move 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset(input logic master);
		model_master = master;
		rst_n = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic load_rom(input logic [17:0] a);
		load_wr = 1'b1;
		load_addr = a;
		load_data = rom_fill(a);
		next_cycle();
		load_wr = 1'b0;
	endtask

	// data checked in the cycle after the address
	task automatic read_expect(input logic [18:0] a, input logic [7:0] want);
		mem_addr = a;
		next_cycle();
		exp_dout = want;
		dout_chk = 1'b1;
		next_cycle();
		dout_chk = 1'b0;
	endtask

	// single low pulse followed by a high cycle
	task automatic write_ram(input logic [17:0] off, input logic [7:0] val);
		mem_addr = {1'b1, off};
		mem_din = val;
		mem_we_n = 1'b0;
		next_cycle();
		mem_we_n = 1'b1;
		next_cycle();
	endtask

	task automatic expect_led(input logic v);
		exp_led = v;
		led_chk = 1'b1;
		next_cycle();
		led_chk = 1'b0;
	endtask

	task automatic end_test(input string name, input int errs_before);
		$display("test %s finished with %0d errors", name, n_errors - errs_before);
	endtask

	// ====================
	// tests
	// ====================

	task automatic test_rom_map();
		int          errs;
		logic [4:0]  map;
		logic [13:0] off;
		logic [3:0]  slot;
		errs = n_errors;
		// both ends of every bank
		for (int b = 0; b < 16; b++) begin
			load_rom({4'(b), 14'h0000});
			load_rom({4'(b), 14'h3fff});
		end
		for (int m = 0; m < 2; m++) begin
			apply_reset(m[0]);
			for (int v = 0; v < 2; v++) begin
				mmfs_v2 = v[0];
				for (int s = 0; s < 32; s++) begin
					slot = 4'(s >> 1);
					off = s[0] ? 14'h3fff : 14'h0000;
					map = ref_rom_map(m[0], v[0], slot);
					read_expect({1'b0, slot, off},
						map[4] ? rom_fill({map[3:0], off}) : 8'h00);
				end
			end
		end
		end_test("rom_map", errs);
	endtask

	task automatic test_ram_writes();
		int          errs;
		logic [17:0] off;
		logic [7:0]  val;
		errs = n_errors;
		for (int i = 0; i < 16; i++) begin
			off = 18'(next_rand() % RAM_DEPTH);
			val = 8'(next_rand());
			write_ram(off, val);
			ram_ref[off] = val;
			ram_offs.push_back(off);
		end
		// later data must not land while the strobe stays low
		off = 18'(next_rand() % RAM_DEPTH);
		val = 8'(next_rand());
		mem_addr = {1'b1, off};
		mem_din = val;
		mem_we_n = 1'b0;
		next_cycle();
		mem_din = ~val;
		next_cycle();
		mem_din = val ^ 8'h5a;
		next_cycle();
		mem_we_n = 1'b1;
		next_cycle();
		ram_ref[off] = val;
		ram_offs.push_back(off);
		foreach (ram_offs[i]) begin
			read_expect({1'b1, ram_offs[i]}, ram_ref[ram_offs[i]]);
		end
		end_test("ram_writes", errs);
	endtask

	task automatic test_mouse();
		int          errs;
		int          dx;
		int          dy;
		int          m_x;
		int          m_y;
		logic        m_on;
		logic [24:0] pkt;
		errs = n_errors;
		m_x = 0;
		m_y = 0;
		m_on = 1'b0;
		mouse_disable = 1'b0;
		joy1_buttons = '0;
		swap_joy = 1'b0;
		joy1_x = 8'h3c;
		joy1_y = 8'hc3;
		next_cycle();
		for (int i = 0; i < 40; i++) begin
			pkt = 25'(next_rand());
			pkt[24] = ~ps2_mouse[24];
			if (i < 15) begin
				// large steps right and up until the position limit
				pkt[4] = 1'b0;
				pkt[15] = 1'b1;
				pkt[5] = 1'b1;
				pkt[23] = 1'b0;
			end
			dx = saturate(field_delta(pkt[4], pkt[15:9]), -MOUSE_STEP_MAX, MOUSE_STEP_MAX);
			dy = saturate(field_delta(pkt[5], pkt[23:17]), -MOUSE_STEP_MAX, MOUSE_STEP_MAX);
			m_x = saturate(m_x + dx, AXIS_MIN, AXIS_MAX);
			m_y = saturate(m_y - dy, AXIS_MIN, AXIS_MAX);
			m_on = 1'b1;
			ps2_mouse = pkt;
			next_cycle();
			exp_j1x = ref_axis(m_on ? 8'(m_x) : joy1_x);
			exp_j1y = ref_axis(m_on ? 8'(m_y) : joy1_y);
			exp_j1f = ~(m_on ? (|pkt[1:0]) : joy1_buttons[4]);
			j1_chk = 1'b1;
			next_cycle();
			j1_chk = 1'b0;
		end
		// back to the analog joystick
		mouse_disable = 1'b1;
		m_on = 1'b0;
		m_x = 0;
		m_y = 0;
		next_cycle();
		exp_j1x = ref_axis(m_on ? 8'(m_x) : joy1_x);
		exp_j1y = ref_axis(m_on ? 8'(m_y) : joy1_y);
		exp_j1f = ~(m_on ? (|ps2_mouse[1:0]) : joy1_buttons[4]);
		j1_chk = 1'b1;
		next_cycle();
		j1_chk = 1'b0;
		end_test("mouse", errs);
	endtask

	task automatic test_joy_routing();
		int          errs;
		logic [31:0] r;
		logic [11:0] a_x;
		logic [11:0] a_y;
		logic [11:0] b_x;
		logic [11:0] b_y;
		errs = n_errors;
		mouse_disable = 1'b1;
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			joy1_x = r[7:0];
			joy1_y = r[15:8];
			joy2_x = r[23:16];
			joy2_y = r[31:24];
			r = next_rand();
			joy1_buttons = r[15:0];
			joy2_fire = r[16];
			swap_joy = i[0];
			a_x = ref_axis(joy1_x);
			a_y = ref_axis(joy1_y);
			b_x = ref_axis(joy2_x);
			b_y = ref_axis(joy2_y);
			exp_j1x = swap_joy ? b_x : a_x;
			exp_j1y = swap_joy ? b_y : a_y;
			exp_j2x = a_x;
			exp_j2y = a_y;
			exp_j1f = ~(swap_joy ? joy2_fire : joy1_buttons[4]);
			exp_j2f = ~(swap_joy ? joy1_buttons[4] : joy2_fire);
			j1_chk = 1'b1;
			j2_chk = 1'b1;
			next_cycle();
		end
		j1_chk = 1'b0;
		j2_chk = 1'b0;
		end_test("joy_routing", errs);
	endtask

	task automatic test_sd_activity();
		int errs;
		errs = n_errors;
		apply_reset(model_master);
		expect_led(1'b0);
		// change seen on the first edge and LED lit on the second
		spi_mosi = ~spi_mosi;
		next_cycle();
		next_cycle();
		expect_led(1'b1);
		repeat (500) next_cycle();
		expect_led(1'b1);
		// LED dark again so that the miso change alone must light it
		apply_reset(model_master);
		expect_led(1'b0);
		spi_miso = ~spi_miso;
		next_cycle();
		next_cycle();
		expect_led(1'b1);
		end_test("sd_activity", errs);
	endtask

	initial begin
		rst_n = 1'b0;
		mem_addr = '0;
		mem_we_n = 1'b1;
		mem_din = '0;
		load_wr = 1'b0;
		load_addr = '0;
		load_data = '0;
		model_master = 1'b0;
		mmfs_v2 = 1'b0;
		ps2_mouse = '0;
		joy1_buttons = '0;
		joy1_x = '0;
		joy1_y = '0;
		joy2_x = '0;
		joy2_y = '0;
		joy2_fire = 1'b0;
		mouse_disable = 1'b0;
		swap_joy = 1'b0;
		spi_mosi = 1'b0;
		spi_miso = 1'b0;
		apply_reset(1'b0);
		test_rom_map();
		test_ram_writes();
		test_mouse();
		test_joy_routing();
		test_sd_activity();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: beeb_glue.f
beeb_glue_pkg.sv
rom_slot_map.sv
beeb_memory.sv
mouse_joystick.sv
sd_activity.sv
beeb_glue.sv
tb_beeb_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of tb_beeb_glue; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_beeb_glue \
	-f beeb_glue.f -o vsim_beeb_glue \
	&& ./obj_dir/vsim_beeb_glue | tee sim.log \
	|| echo "build or run did not complete"
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
